//--- hdl/stat_params.svh
`ifndef STAT_PARAMS_SVH
`define STAT_PARAMS_SVH

// Sample and result widths
`define STAT_SAMPLE_W 8
`define STAT_SUM_W 24
`define STAT_SQSUM_W 32

// Accumulator pipeline depth on the sum path
// Square path runs one stage shorter to stay aligned
`define STAT_STAGES 2

// Register byte offsets seen by the host
`define STAT_ADDR_SUM 4'h0
`define STAT_ADDR_SQSUM 4'h4
`define STAT_ADDR_CTRL 4'h8

// CTRL bit that starts a clear
`define STAT_CTRL_CLR_BIT 0

`endif

//--- hdl/stat_types_pkg.sv
`include "stat_params.svh"

package stat_types_pkg;

  // One incoming sample, unsigned
  typedef logic [`STAT_SAMPLE_W-1:0] sample_t;

  // Square of a single sample, full width so it never truncates
  typedef logic [2*`STAT_SAMPLE_W-1:0] square_t;

  // Running sum of samples
  // Wraps modulo 2^STAT_SUM_W
  typedef logic [`STAT_SUM_W-1:0] sum_t;

  // Running sum of squares
  // Wraps modulo 2^STAT_SQSUM_W
  typedef logic [`STAT_SQSUM_W-1:0] sqsum_t;

endpackage

//--- hdl/axil_pkg.sv
package axil_pkg;

  // Byte address inside the register block
  // Four registers of 32 bits fit in 16 bytes
  typedef logic [3:0] addr_t;

  // Read and write data bus
  typedef logic [31:0] data_t;

  // Response field on B and R channels
  typedef logic [1:0] resp_t;

  // Normal completion
  localparam resp_t RESP_OKAY = 2'b00;

  // Unmapped offset or illegal access
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- hdl/pipe_accumulator.sv
`timescale 1ns/1ps

module pipe_accumulator #(
  parameter type acc_t = logic [7:0],
  parameter int STAGES = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic clr,
  input  logic en,
  input  acc_t val,
  output acc_t acc
);

  // Index 0 is the input register, the rest are plain delays
  acc_t val_q [STAGES];
  logic [STAGES-1:0] en_q;

  // Enable chain, emptied on clear so in-flight values are dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_q <= '0;
    end else if (clr) begin
      en_q <= '0;
    end else begin
      en_q[0] <= en;
      for (int i = 1; i < STAGES; i++) begin
        en_q[i] <= en_q[i-1];
      end
    end
  end

  // Value chain follows the enable chain
  always_ff @(posedge clk) begin
    if (clr) begin
      for (int i = 0; i < STAGES; i++) begin
        val_q[i] <= '0;
      end
    end else begin
      val_q[0] <= val;
      for (int i = 1; i < STAGES; i++) begin
        val_q[i] <= val_q[i-1];
      end
    end
  end

  // Adding register at the end of the chain
  // Plain modulo add, no saturation
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (clr) begin
      acc <= '0;
    end else if (en_q[STAGES-1]) begin
      acc <= acc + val_q[STAGES-1];
    end
  end

endmodule

//--- hdl/square_stage.sv
`timescale 1ns/1ps

module square_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clr,
  input  logic                    en,
  input  stat_types_pkg::sample_t val,
  output stat_types_pkg::square_t sq,
  output logic                    sq_en
);

  // Operands widened first so the product keeps all its bits
  stat_types_pkg::square_t val_wide;

  assign val_wide = stat_types_pkg::square_t'(val);

  // Square captured only for enabled samples
  always_ff @(posedge clk) begin
    if (en) begin
      sq <= val_wide * val_wide;
    end
  end

  // Enable travels one cycle behind the sample
  // Forced low on clear so the square in flight never reaches the accumulator
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sq_en <= 1'b0;
    end else if (clr) begin
      sq_en <= 1'b0;
    end else begin
      sq_en <= en;
    end
  end

endmodule

//--- hdl/stat_regs_axil.sv
`timescale 1ns/1ps
`include "stat_params.svh"

module stat_regs_axil (
  input  logic                    clk,
  input  logic                    rst_n,
  // Write address channel
  input  axil_pkg::addr_t         awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  // Write data channel
  input  axil_pkg::data_t         wdata,
  input  logic                    wvalid,
  output logic                    wready,
  // Write response channel
  output axil_pkg::resp_t         bresp,
  output logic                    bvalid,
  input  logic                    bready,
  // Read address channel
  input  axil_pkg::addr_t         araddr,
  input  logic                    arvalid,
  output logic                    arready,
  // Read data channel
  output axil_pkg::data_t         rdata,
  output axil_pkg::resp_t         rresp,
  output logic                    rvalid,
  input  logic                    rready,
  // Results and control
  input  stat_types_pkg::sum_t    sum_acc,
  input  stat_types_pkg::sqsum_t  sqsum_acc,
  output logic                    clr
);

  logic wr_accept;
  logic rd_accept;
  logic wr_is_ctrl;

  // Sum of squares frozen on each SUM read
  stat_types_pkg::sqsum_t sqsum_shadow;

  // Address and data taken in the same cycle, only with no response pending
  assign wr_accept = awvalid && wvalid && !bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign wr_is_ctrl = (awaddr == `STAT_ADDR_CTRL);

  // One read at a time
  assign arready   = !rvalid;
  assign rd_accept = arvalid && arready;

  // Write response and the one-cycle clear pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      bresp  <= axil_pkg::RESP_OKAY;
      clr    <= 1'b0;
    end else begin
      clr <= wr_accept && wr_is_ctrl && wdata[`STAT_CTRL_CLR_BIT];
      if (wr_accept) begin
        bvalid <= 1'b1;
        // Only CTRL is writable
        bresp  <= wr_is_ctrl ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Read valid and response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
      rresp  <= axil_pkg::RESP_OKAY;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
      case (araddr)
        `STAT_ADDR_SUM, `STAT_ADDR_SQSUM, `STAT_ADDR_CTRL: rresp <= axil_pkg::RESP_OKAY;
        default: rresp <= axil_pkg::RESP_SLVERR;
      endcase
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Read data held until rready
  // CTRL reads back as zero, the clear is self-clearing
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      case (araddr)
        `STAT_ADDR_SUM:   rdata <= axil_pkg::data_t'(sum_acc);
        `STAT_ADDR_SQSUM: rdata <= axil_pkg::data_t'(sqsum_shadow);
        default:          rdata <= '0;
      endcase
    end
  end

  // Shadow pairs the next SQSUM read with this SUM read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sqsum_shadow <= '0;
    end else if (clr) begin
      sqsum_shadow <= '0;
    end else if (rd_accept && (araddr == `STAT_ADDR_SUM)) begin
      sqsum_shadow <= sqsum_acc;
    end
  end

endmodule

//--- hdl/stream_stats_top.sv
`timescale 1ns/1ps
`include "stat_params.svh"

module stream_stats_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // Sample stream
  input  logic                    en,
  input  stat_types_pkg::sample_t val,
  // AXI4-Lite host port
  input  axil_pkg::addr_t         awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  axil_pkg::data_t         wdata,
  input  logic                    wvalid,
  output logic                    wready,
  output axil_pkg::resp_t         bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  axil_pkg::addr_t         araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output axil_pkg::data_t         rdata,
  output axil_pkg::resp_t         rresp,
  output logic                    rvalid,
  input  logic                    rready
);

  logic                    clr;
  logic                    sq_en;
  stat_types_pkg::square_t sq;
  stat_types_pkg::sum_t    sum_acc;
  stat_types_pkg::sqsum_t  sqsum_acc;

  // Sum path, sample zero-extended into the sum width
  pipe_accumulator #(
    .acc_t  (stat_types_pkg::sum_t),
    .STAGES (`STAT_STAGES)
  ) u_sum_acc (
    .clk   (clk),
    .rst_n (rst_n),
    .clr   (clr),
    .en    (en),
    .val   (stat_types_pkg::sum_t'(val)),
    .acc   (sum_acc)
  );

  // Square path
  square_stage u_square (
    .clk   (clk),
    .rst_n (rst_n),
    .clr   (clr),
    .en    (en),
    .val   (val),
    .sq    (sq),
    .sq_en (sq_en)
  );

  // One stage shorter, the squarer supplies the missing cycle
  pipe_accumulator #(
    .acc_t  (stat_types_pkg::sqsum_t),
    .STAGES (`STAT_STAGES - 1)
  ) u_sqsum_acc (
    .clk   (clk),
    .rst_n (rst_n),
    .clr   (clr),
    .en    (sq_en),
    .val   (stat_types_pkg::sqsum_t'(sq)),
    .acc   (sqsum_acc)
  );

  // Host registers and clear source
  stat_regs_axil u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .sum_acc   (sum_acc),
    .sqsum_acc (sqsum_acc),
    .clr       (clr)
  );

endmodule

//--- verification/stream_stats_assert.sv
`timescale 1ns/1ps
`include "stat_params.svh"

module stream_stats_assert (
  input logic                   clk,
  input logic                   rst_n,
  input axil_pkg::addr_t        awaddr,
  input logic                   awvalid,
  input logic                   awready,
  input axil_pkg::data_t        wdata,
  input logic                   wvalid,
  input logic                   wready,
  input logic                   bvalid,
  input logic                   bready,
  input logic                   rvalid,
  input logic                   rready,
  input axil_pkg::data_t        rdata,
  input logic                   clr,
  input stat_types_pkg::sum_t   sum_acc,
  input stat_types_pkg::sqsum_t sqsum_acc
);

  // Failed assertions so far
  int fail_count = 0;

  // Write response held until the host takes it
  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  // Read data frozen while stalled
  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      fail_count++;
      $error("rvalid or rdata changed before rready");
    end

  // Single-cycle clear, on the edge after an accepted CTRL write with the clear bit
  clr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    clr == $past(awvalid && awready && wvalid && wready &&
                 (awaddr == `STAT_ADDR_CTRL) && wdata[`STAT_CTRL_CLR_BIT]))
    else begin
      fail_count++;
      $error("clr does not follow an accepted CTRL clear write");
    end

  // Both sums empty right after a clear
  clr_zero: assert property (@(posedge clk) disable iff (!rst_n)
    clr |=> (sum_acc == '0) && (sqsum_acc == '0))
    else begin
      fail_count++;
      $error("sums not zero after clr");
    end

endmodule

bind stat_regs_axil stream_stats_assert u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .awaddr    (awaddr),
  .awvalid   (awvalid),
  .awready   (awready),
  .wdata     (wdata),
  .wvalid    (wvalid),
  .wready    (wready),
  .bvalid    (bvalid),
  .bready    (bready),
  .rvalid    (rvalid),
  .rready    (rready),
  .rdata     (rdata),
  .clr       (clr),
  .sum_acc   (sum_acc),
  .sqsum_acc (sqsum_acc)
);

//--- verification/stream_stats_tb.sv
`timescale 1ns/1ps
`include "stat_params.svh"

module stream_stats_tb;

  // 0xFF samples needed to overflow both sums, with some margin
  localparam int WRAP_SAMPLES = 66200;
  // Wrap test dominates the run length
  localparam int TIMEOUT_CYCLES = 4 * (WRAP_SAMPLES + 300);

  logic clk;
  logic rst_n;
  logic en;
  stat_types_pkg::sample_t val;
  axil_pkg::addr_t awaddr;
  axil_pkg::addr_t araddr;
  axil_pkg::data_t wdata;
  axil_pkg::data_t rdata;
  axil_pkg::resp_t bresp;
  axil_pkg::resp_t rresp;
  logic awvalid, awready, wvalid, wready;
  logic bvalid, bready;
  logic arvalid, arready, rvalid, rready;

  // Reference sums, wrapping at the register widths
  stat_types_pkg::sum_t model_sum;
  stat_types_pkg::sqsum_t model_sqsum;
  stat_types_pkg::sample_t stim[$];
  int cycle_count = 0;

  stream_stats_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped");
  endtask

  // Watchdog on total cycles
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Run timed out after %0d cycles", cycle_count));
    end
  end

  // Register block checker, looked at away from the rising edge
  always @(negedge clk) begin
    if (DUT.u_regs.u_assert.fail_count != 0) begin
      fail_run("An assertion on the register block failed");
    end
  end

  task automatic check_sum(input string name, input stat_types_pkg::sum_t got,
                           input stat_types_pkg::sum_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_sqsum(input string name, input stat_types_pkg::sqsum_t got,
                             input stat_types_pkg::sqsum_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input axil_pkg::resp_t got,
                            input axil_pkg::resp_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Address and data offered together, response stalled one cycle before bready
  task automatic axi_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                           output axil_pkg::resp_t resp);
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b0;
    // Both ready flags up together while no response is pending
    #1;
    check_flag("awready", awready, 1'b1);
    check_flag("wready", wready, 1'b1);
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    resp = bresp;
    // One cycle with bvalid up and bready low
    @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  // hold = cycles of rready low after rvalid shows up
  task automatic axi_read(input axil_pkg::addr_t addr, input int hold,
                          output axil_pkg::data_t data, output axil_pkg::resp_t resp);
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    rready = (hold == 0);
    // No read in flight, so the address is taken at once
    #1;
    check_flag("arready", arready, 1'b1);
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    arvalid = 1'b0;
    data = rdata;
    resp = rresp;
    repeat (hold) @(negedge clk);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Drains the stimulus queue, one sample per cycle
  task automatic send_samples();
    stat_types_pkg::sample_t s;
    while (stim.size() > 0) begin
      s = stim.pop_front();
      @(negedge clk);
      en = 1'b1;
      val = s;
      model_sum = model_sum + stat_types_pkg::sum_t'(s);
      model_sqsum = model_sqsum + stat_types_pkg::sqsum_t'(s) * stat_types_pkg::sqsum_t'(s);
    end
    @(negedge clk);
    en = 1'b0;
  endtask

  // Let the pipeline drain, then read the SUM/SQSUM pair
  task automatic check_totals();
    axil_pkg::data_t data;
    axil_pkg::resp_t resp;
    repeat (`STAT_STAGES + 1) @(posedge clk);
    axi_read(`STAT_ADDR_SUM, 0, data, resp);
    check_resp("rresp", resp, axil_pkg::RESP_OKAY);
    check_sum("sum", stat_types_pkg::sum_t'(data), model_sum);
    axi_read(`STAT_ADDR_SQSUM, 0, data, resp);
    check_resp("rresp", resp, axil_pkg::RESP_OKAY);
    check_sqsum("sqsum", stat_types_pkg::sqsum_t'(data), model_sqsum);
  endtask

  task automatic accumulate_samples();
    for (int i = 1; i <= 5; i++) begin
      stim.push_back(stat_types_pkg::sample_t'(i));
      send_samples();
      check_totals();
    end
    // Back-to-back burst
    repeat (20) stim.push_back(stat_types_pkg::sample_t'($urandom_range(255)));
    send_samples();
    check_totals();
  endtask

  task automatic wrap_sums();
    repeat (WRAP_SAMPLES) stim.push_back(8'hFF);
    send_samples();
    check_totals();
  endtask

  task automatic reject_bad_access();
    axil_pkg::data_t data;
    axil_pkg::resp_t resp;
    // SUM is read-only
    axi_write(`STAT_ADDR_SUM, 32'h00AB_CDEF, resp);
    check_resp("bresp", resp, axil_pkg::RESP_SLVERR);
    axi_read(4'hC, 0, data, resp);
    check_resp("rresp", resp, axil_pkg::RESP_SLVERR);
    check_totals();
  endtask

  task automatic clear_in_flight();
    axil_pkg::resp_t resp;
    // Sample enabled at the same edge that accepts the write
    stim.push_back(8'h5A);
    fork
      send_samples();
      axi_write(`STAT_ADDR_CTRL, 32'h1, resp);
    join
    check_resp("bresp", resp, axil_pkg::RESP_OKAY);
    model_sum = '0;
    model_sqsum = '0;
    check_totals();
    repeat (8) stim.push_back(stat_types_pkg::sample_t'($urandom_range(255)));
    send_samples();
    check_totals();
  endtask

  task automatic hold_snapshot();
    axil_pkg::data_t data;
    axil_pkg::resp_t resp;
    stat_types_pkg::sqsum_t sqsum_at_read;
    repeat (6) stim.push_back(stat_types_pkg::sample_t'($urandom_range(255)));
    send_samples();
    repeat (`STAT_STAGES + 1) @(posedge clk);
    axi_read(`STAT_ADDR_SUM, 6, data, resp);
    check_sum("sum", stat_types_pkg::sum_t'(data), model_sum);
    sqsum_at_read = model_sqsum;
    // More samples land between the two reads
    repeat (10) stim.push_back(stat_types_pkg::sample_t'($urandom_range(255)));
    send_samples();
    repeat (`STAT_STAGES + 1) @(posedge clk);
    axi_read(`STAT_ADDR_SQSUM, 4, data, resp);
    check_resp("rresp", resp, axil_pkg::RESP_OKAY);
    check_sqsum("sqsum shadow", stat_types_pkg::sqsum_t'(data), sqsum_at_read);
    check_totals();
  endtask

  initial begin
    void'($urandom(95491));
    rst_n = 1'b0;
    en = 1'b0;
    val = '0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    model_sum = '0;
    model_sqsum = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    // Reset values first
    check_totals();
    accumulate_samples();
    wrap_sums();
    reject_bad_access();
    clear_in_flight();
    hold_snapshot();
    if (DUT.u_regs.u_assert.fail_count != 0) begin
      fail_run("An assertion on the register block failed");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- project.f
+incdir+hdl
hdl/stat_types_pkg.sv
hdl/axil_pkg.sv
hdl/pipe_accumulator.sv
hdl/square_stage.sv
hdl/stat_regs_axil.sv
hdl/stream_stats_top.sv
verification/stream_stats_assert.sv
verification/stream_stats_tb.sv
